// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/alu.sv
// result is combinational; flags {zero, negative, carry} update only on i_flags_en, carry is borrow on SUB
`timescale 1ns/1ps

module alu (
	input  logic                        clk,
	input  logic                        reset,
	input  cpu_pkg::alu_op_t            i_op,
	input  logic [cpu_pkg::DATA_W-1:0]  i_a,
	input  logic [cpu_pkg::DATA_W-1:0]  i_b,
	input  logic                        i_flags_en,
	output logic [cpu_pkg::DATA_W-1:0]  o_result,
	output logic [cpu_pkg::FLAGS_W-1:0] o_flags
);
	import cpu_pkg::*;

	// one extra bit keeps the carry or borrow
	logic [DATA_W:0]    wide;
	logic [FLAGS_W-1:0] flags_d;

	always_comb
	begin
		case (i_op)
			ADD:     wide = {1'b0, i_a} + {1'b0, i_b};
			SUB:     wide = {1'b0, i_a} - {1'b0, i_b};
			AND:     wide = {1'b0, i_a & i_b};
			XOR:     wide = {1'b0, i_a ^ i_b};
			default: wide = '0;
		endcase
	end

	assign o_result = wide[DATA_W-1:0];

	always_comb
	begin
		flags_d         = '0;
		flags_d[FLAG_Z] = (o_result == '0);
		flags_d[FLAG_N] = o_result[DATA_W-1];
		// logic ops leave the top bit clear, so carry reads 0
		flags_d[FLAG_C] = wide[DATA_W];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			o_flags <= '0;
		else if (i_flags_en)
			o_flags <= flags_d;
	end

endmodule

// File: hw/cpu_fsm.sv
// one instruction in flight; rType/iType take 3 cycles, pType 5, jType 5; reset forces all strobes low
`timescale 1ns/1ps

module cpu_fsm (
	input  logic            clk,
	input  logic            reset,
	input  cpu_pkg::itype_t i_type,
	input  logic            i_wb,
	output logic            o_ir_en,
	output logic            o_ls_pc_sel,
	output logic            o_imm_sel,
	output logic            o_reg_wen,
	output logic            o_flags_en,
	output logic            o_mem_we,
	output logic            o_mem_to_reg,
	output logic            o_link_sel,
	output logic            o_pc_en,
	output logic            o_pc_jump,
	output logic            o_retire
);
	import cpu_pkg::*;

	localparam logic [3:0] FETCH        = 4'd0;
	localparam logic [3:0] DECODE       = 4'd1;
	localparam logic [3:0] EXEC_ALU     = 4'd2;
	localparam logic [3:0] MEM_SETUP    = 4'd3;
	localparam logic [3:0] MEM_ACCESS   = 4'd4;
	localparam logic [3:0] MEM_DONE     = 4'd5;
	localparam logic [3:0] JUMP_LINK    = 4'd6;
	localparam logic [3:0] JUMP_SETTLE1 = 4'd7;
	localparam logic [3:0] JUMP_SETTLE2 = 4'd8;

	logic [3:0] state;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= FETCH;
		else
		begin
			case (state)
				FETCH:
					state <= DECODE;
				// branch on the instruction type
				DECODE:
					case (i_type)
						R_TYPE, I_TYPE: state <= EXEC_ALU;
						P_TYPE:         state <= MEM_SETUP;
						J_TYPE:         state <= JUMP_LINK;
						default:        state <= FETCH;
					endcase
				EXEC_ALU:     state <= FETCH;
				MEM_SETUP:    state <= MEM_ACCESS;
				MEM_ACCESS:   state <= MEM_DONE;
				MEM_DONE:     state <= FETCH;
				JUMP_LINK:    state <= JUMP_SETTLE1;
				JUMP_SETTLE1: state <= JUMP_SETTLE2;
				JUMP_SETTLE2: state <= FETCH;
				default:      state <= FETCH;
			endcase
		end
	end

	always_comb
	begin
		// idle values, memory addressed by the pc
		o_ir_en      = 1'b0;
		o_ls_pc_sel  = 1'b1;
		o_imm_sel    = 1'b0;
		o_reg_wen    = 1'b0;
		o_flags_en   = 1'b0;
		o_mem_we     = 1'b0;
		o_mem_to_reg = 1'b0;
		o_link_sel   = 1'b0;
		o_pc_en      = 1'b0;
		o_pc_jump    = 1'b0;
		o_retire     = 1'b0;

		case (state)
			FETCH:
				o_ir_en = 1'b1;
			DECODE:
				o_imm_sel = (i_type == I_TYPE);
			// alu result goes back to rd only when wb is set
			EXEC_ALU:
			begin
				o_imm_sel  = (i_type == I_TYPE);
				o_reg_wen  = i_wb;
				o_flags_en = 1'b1;
				o_pc_en    = 1'b1;
				o_retire   = 1'b1;
			end
			// wb=1 is a store, wb=0 a load; both held for two cycles
			MEM_SETUP, MEM_ACCESS:
			begin
				o_ls_pc_sel  = 1'b0;
				o_mem_we     = i_wb;
				o_mem_to_reg = ~i_wb;
				o_reg_wen    = ~i_wb;
			end
			MEM_DONE:
			begin
				o_pc_en  = 1'b1;
				o_retire = 1'b1;
			end
			// pc takes rs, rd takes the old pc+1 if linking
			JUMP_LINK:
			begin
				o_pc_en    = 1'b1;
				o_pc_jump  = 1'b1;
				o_link_sel = i_wb;
				o_reg_wen  = i_wb;
			end
			JUMP_SETTLE2:
				o_retire = 1'b1;
			default:
				o_ir_en = 1'b0;
		endcase

		if (reset)
		begin
			o_ir_en    = 1'b0;
			o_reg_wen  = 1'b0;
			o_flags_en = 1'b0;
			o_mem_we   = 1'b0;
			o_pc_en    = 1'b0;
			o_retire   = 1'b0;
		end
	end

endmodule

// File: hw/cpu_pkg.sv
// shared widths and encodings; DATA_W is fixed at 16 and the instr_u field order is the instruction encoding
package cpu_pkg;

	localparam int DATA_W    = 16;
	localparam int ADDR_W    = 8;
	localparam int REG_IDX_W = 3;
	localparam int FLAGS_W   = 3;

	// immediate takes whatever is left below type, wb, op and rd
	localparam int IMM_W = DATA_W - 2 - 1 - 2 - REG_IDX_W;

	// bit positions inside the flags word
	localparam int FLAG_Z = 2;
	localparam int FLAG_N = 1;
	localparam int FLAG_C = 0;

	typedef enum logic [1:0] {
		R_TYPE = 2'b00,
		I_TYPE = 2'b01,
		P_TYPE = 2'b10,
		J_TYPE = 2'b11
	} itype_t;

	typedef enum logic [1:0] {
		ADD = 2'b00,
		SUB = 2'b01,
		AND = 2'b10,
		XOR = 2'b11
	} alu_op_t;

	// register view: rd op= rs, loads, stores and jumps
	typedef struct packed {
		itype_t               itype;
		logic                 wb;
		alu_op_t              op;
		logic [REG_IDX_W-1:0] rd;
		logic [REG_IDX_W-1:0] rs;
		logic [IMM_W-REG_IDX_W-1:0] unused;
	} instr_reg_t;

	// immediate view: rd op= imm, imm is zero-extended
	typedef struct packed {
		itype_t               itype;
		logic                 wb;
		alu_op_t              op;
		logic [REG_IDX_W-1:0] rd;
		logic [IMM_W-1:0]     imm;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

endpackage

// File: hw/cpu_top.sv
// load port and debug port are meant for use while reset is held; rs supplies both memory address and jump target
`timescale 1ns/1ps

module cpu_top #(
	parameter int MEM_DEPTH = 256,
	parameter int NUM_REGS  = 8
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_load_en,
	input  logic [cpu_pkg::ADDR_W-1:0]    i_load_addr,
	input  logic [cpu_pkg::DATA_W-1:0]    i_load_data,
	input  logic [cpu_pkg::REG_IDX_W-1:0] i_dbg_idx,
	output logic [cpu_pkg::DATA_W-1:0]    o_dbg_data,
	output logic [cpu_pkg::ADDR_W-1:0]    o_pc,
	output logic [cpu_pkg::FLAGS_W-1:0]   o_flags,
	output logic                          o_retire
);
	import cpu_pkg::*;

	instr_u ir;

	logic [DATA_W-1:0] mem_rd_data;
	logic [DATA_W-1:0] rd_data;
	logic [DATA_W-1:0] rs_data;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_result;
	logic [DATA_W-1:0] wb_data;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pc_plus1;

	logic ir_en;
	logic ls_pc_sel;
	logic imm_sel;
	logic reg_wen;
	logic flags_en;
	logic mem_we;
	logic mem_to_reg;
	logic link_sel;
	logic pc_en;
	logic pc_jump;

	// instruction register, loaded in FETCH
	always_ff @(posedge clk)
	begin
		if (ir_en)
			ir <= mem_rd_data;
	end

	assign alu_b = imm_sel ? {{(DATA_W-IMM_W){1'b0}}, ir.i.imm} : rs_data;

	// link beats memory data beats alu result
	always_comb
	begin
		if (link_sel)
			wb_data = {{(DATA_W-ADDR_W){1'b0}}, pc_plus1};
		else if (mem_to_reg)
			wb_data = mem_rd_data;
		else
			wb_data = alu_result;
	end

	assign o_pc = pc;

	cpu_fsm u_cpu_fsm (
		.clk          (clk),
		.reset        (reset),
		.i_type       (ir.r.itype),
		.i_wb         (ir.r.wb),
		.o_ir_en      (ir_en),
		.o_ls_pc_sel  (ls_pc_sel),
		.o_imm_sel    (imm_sel),
		.o_reg_wen    (reg_wen),
		.o_flags_en   (flags_en),
		.o_mem_we     (mem_we),
		.o_mem_to_reg (mem_to_reg),
		.o_link_sel   (link_sel),
		.o_pc_en      (pc_en),
		.o_pc_jump    (pc_jump),
		.o_retire     (o_retire)
	);

	reg_file #(
		.NUM_REGS (NUM_REGS)
	) u_reg_file (
		.clk         (clk),
		.reset       (reset),
		.i_wen       (reg_wen),
		.i_wr_idx    (ir.r.rd),
		.i_wr_data   (wb_data),
		.i_rd_idx_a  (ir.r.rd),
		.i_rd_idx_b  (ir.r.rs),
		.i_dbg_idx   (i_dbg_idx),
		.o_rd_data_a (rd_data),
		.o_rd_data_b (rs_data),
		.o_dbg_data  (o_dbg_data)
	);

	alu u_alu (
		.clk        (clk),
		.reset      (reset),
		.i_op       (ir.r.op),
		.i_a        (rd_data),
		.i_b        (alu_b),
		.i_flags_en (flags_en),
		.o_result   (alu_result),
		.o_flags    (o_flags)
	);

	pc_unit u_pc_unit (
		.clk        (clk),
		.reset      (reset),
		.i_pc_en    (pc_en),
		.i_jump     (pc_jump),
		.i_target   (rs_data[ADDR_W-1:0]),
		.o_pc       (pc),
		.o_pc_plus1 (pc_plus1)
	);

	unified_mem #(
		.MEM_DEPTH (MEM_DEPTH)
	) u_unified_mem (
		.clk         (clk),
		.i_pc_sel    (ls_pc_sel),
		.i_pc        (pc),
		.i_reg_addr  (rs_data[ADDR_W-1:0]),
		.i_we        (mem_we),
		.i_wr_data   (rd_data),
		.i_load_en   (i_load_en),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.o_rd_data   (mem_rd_data)
	);

endmodule

// File: hw/pc_unit.sv
// 8-bit pc wraps at 256; a smaller power-of-two memory aliases the upper addresses
`timescale 1ns/1ps

module pc_unit (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_pc_en,
	input  logic                       i_jump,
	input  logic [cpu_pkg::ADDR_W-1:0] i_target,
	output logic [cpu_pkg::ADDR_W-1:0] o_pc,
	output logic [cpu_pkg::ADDR_W-1:0] o_pc_plus1
);

	// also the link value for jType
	assign o_pc_plus1 = o_pc + 1'b1;

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_pc_en)
		begin
			if (i_jump)
				o_pc <= i_target;
			else
				o_pc <= o_pc_plus1;
		end
	end

endmodule

// File: hw/reg_file.sv
// registers clear to zero on reset; indices at or above NUM_REGS read as zero and ignore writes
`timescale 1ns/1ps

module reg_file #(
	parameter int NUM_REGS = 8
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_wen,
	input  logic [cpu_pkg::REG_IDX_W-1:0] i_wr_idx,
	input  logic [cpu_pkg::DATA_W-1:0]    i_wr_data,
	input  logic [cpu_pkg::REG_IDX_W-1:0] i_rd_idx_a,
	input  logic [cpu_pkg::REG_IDX_W-1:0] i_rd_idx_b,
	input  logic [cpu_pkg::REG_IDX_W-1:0] i_dbg_idx,
	output logic [cpu_pkg::DATA_W-1:0]    o_rd_data_a,
	output logic [cpu_pkg::DATA_W-1:0]    o_rd_data_b,
	output logic [cpu_pkg::DATA_W-1:0]    o_dbg_data
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (i_wen && (i_wr_idx < NUM_REGS))
			regs[i_wr_idx] <= i_wr_data;
	end

	// combinational reads, a is rd and b is rs in the core
	assign o_rd_data_a = (i_rd_idx_a < NUM_REGS) ? regs[i_rd_idx_a] : '0;
	assign o_rd_data_b = (i_rd_idx_b < NUM_REGS) ? regs[i_rd_idx_b] : '0;

	// inspection port for the testbench
	assign o_dbg_data = (i_dbg_idx < NUM_REGS) ? regs[i_dbg_idx] : '0;

endmodule

// File: hw/unified_mem.sv
// MEM_DEPTH must be a power of two no larger than 256; load port wins over a core write in the same cycle
`timescale 1ns/1ps

module unified_mem #(
	parameter int MEM_DEPTH = 256
) (
	input  logic                       clk,
	input  logic                       i_pc_sel,
	input  logic [cpu_pkg::ADDR_W-1:0] i_pc,
	input  logic [cpu_pkg::ADDR_W-1:0] i_reg_addr,
	input  logic                       i_we,
	input  logic [cpu_pkg::DATA_W-1:0] i_wr_data,
	input  logic                       i_load_en,
	input  logic [cpu_pkg::ADDR_W-1:0] i_load_addr,
	input  logic [cpu_pkg::DATA_W-1:0] i_load_data,
	output logic [cpu_pkg::DATA_W-1:0] o_rd_data
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(MEM_DEPTH);

	logic [DATA_W-1:0] mem [MEM_DEPTH];
	logic [ADDR_W-1:0] addr;

	// instruction fetch uses the pc, loads and stores use rs
	assign addr = i_pc_sel ? i_pc : i_reg_addr;

	assign o_rd_data = mem[addr[IDX_W-1:0]];

	always_ff @(posedge clk)
	begin
		if (i_load_en)
			mem[i_load_addr[IDX_W-1:0]] <= i_load_data;
		else if (i_we)
			mem[addr[IDX_W-1:0]] <= i_wr_data;
	end

endmodule

// File: tb/cpu_tb.sv
// program is 16 words loaded while reset is held; the last instruction spins in place so registers can be read back
`timescale 1ns/1ps

module cpu_tb;

	localparam int PROG_LEN       = 16;
	localparam int TRACE_LEN      = 16;
	localparam int RESET_CYCLES   = 16;
	localparam int RETIRE_TIMEOUT = 20;

	// instruction type and alu op encodings
	localparam logic [1:0] T_R    = 2'b00;
	localparam logic [1:0] T_I    = 2'b01;
	localparam logic [1:0] T_P    = 2'b10;
	localparam logic [1:0] T_J    = 2'b11;
	localparam logic [1:0] OP_ADD = 2'b00;
	localparam logic [1:0] OP_SUB = 2'b01;
	localparam logic [1:0] OP_AND = 2'b10;
	localparam logic [1:0] OP_XOR = 2'b11;

	logic        clk;
	logic        reset;
	logic        load_en;
	logic [7:0]  load_addr;
	logic [15:0] load_data;
	logic [2:0]  dbg_idx;
	logic [15:0] dbg_data;
	logic [7:0]  pc;
	logic [2:0]  flags;
	logic        retire;

	logic [15:0] prog [PROG_LEN];
	string       trace_name [TRACE_LEN];
	int          trace_cycles [TRACE_LEN];
	logic [7:0]  trace_next_pc [TRACE_LEN];
	logic [2:0]  trace_flags [TRACE_LEN];
	logic [15:0] reg_expect [8];

	int cycle;
	int last_retire;

	cpu_top #(
		.MEM_DEPTH (256),
		.NUM_REGS  (8)
	) u_cpu_top (
		.clk         (clk),
		.reset       (reset),
		.i_load_en   (load_en),
		.i_load_addr (load_addr),
		.i_load_data (load_data),
		.i_dbg_idx   (dbg_idx),
		.o_dbg_data  (dbg_data),
		.o_pc        (pc),
		.o_flags     (flags),
		.o_retire    (retire)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// register view: type, wb, op, rd, rs, five unused bits
	function automatic logic [15:0] enc_reg(input logic [1:0] itype, input logic wb,
		input logic [1:0] op, input logic [2:0] rd, input logic [2:0] rs);
		return {itype, wb, op, rd, rs, 5'b00000};
	endfunction

	function automatic logic [15:0] enc_imm(input logic [1:0] itype, input logic wb,
		input logic [1:0] op, input logic [2:0] rd, input logic [7:0] imm);
		return {itype, wb, op, rd, imm};
	endfunction

	task automatic set_trace(input int idx, input string name, input int cycles,
		input logic [7:0] next_pc, input logic [2:0] exp_flags);
		trace_name[idx]    = name;
		trace_cycles[idx]  = cycles;
		trace_next_pc[idx] = next_pc;
		trace_flags[idx]   = exp_flags;
	endtask

	task automatic build_tables();
		prog[0]  = enc_imm(T_I, 1'b1, OP_ADD, 3'd1, 8'h25);
		prog[1]  = enc_imm(T_I, 1'b1, OP_XOR, 3'd2, 8'h5a);
		prog[2]  = enc_reg(T_R, 1'b1, OP_ADD, 3'd3, 3'd1);
		prog[3]  = enc_reg(T_R, 1'b1, OP_SUB, 3'd3, 3'd1);
		prog[4]  = enc_reg(T_R, 1'b1, OP_SUB, 3'd4, 3'd2);
		prog[5]  = enc_reg(T_R, 1'b1, OP_AND, 3'd2, 3'd4);
		prog[6]  = enc_reg(T_R, 1'b0, OP_SUB, 3'd1, 3'd1);
		prog[7]  = enc_imm(T_I, 1'b1, OP_ADD, 3'd5, 8'h80);
		prog[8]  = enc_reg(T_P, 1'b1, OP_ADD, 3'd4, 3'd5);
		prog[9]  = enc_reg(T_P, 1'b0, OP_ADD, 3'd6, 3'd5);
		prog[10] = enc_imm(T_I, 1'b1, OP_ADD, 3'd7, 8'd13);
		prog[11] = enc_reg(T_J, 1'b1, OP_ADD, 3'd3, 3'd7);
		// jumped over
		prog[12] = enc_imm(T_I, 1'b1, OP_ADD, 3'd1, 8'h11);
		prog[13] = enc_imm(T_I, 1'b1, OP_ADD, 3'd7, 8'd2);
		prog[14] = enc_reg(T_J, 1'b0, OP_ADD, 3'd2, 3'd7);
		prog[15] = enc_reg(T_J, 1'b0, OP_ADD, 3'd0, 3'd7);

		// expected flags are {zero, negative, carry}
		set_trace(0, "addi r1", 3, 8'd1, 3'b000);
		set_trace(1, "xori r2", 3, 8'd2, 3'b000);
		set_trace(2, "add r3", 3, 8'd3, 3'b000);
		set_trace(3, "sub r3 to zero", 3, 8'd4, 3'b100);
		set_trace(4, "sub r4 borrow", 3, 8'd5, 3'b011);
		set_trace(5, "and r2", 3, 8'd6, 3'b000);
		set_trace(6, "sub r1 no write", 3, 8'd7, 3'b100);
		set_trace(7, "addi r5", 3, 8'd8, 3'b000);
		set_trace(8, "store r4", 5, 8'd9, 3'b000);
		set_trace(9, "load r6", 5, 8'd10, 3'b000);
		set_trace(10, "addi r7", 3, 8'd11, 3'b000);
		set_trace(11, "jump link r3", 5, 8'd13, 3'b000);
		set_trace(12, "addi r7 again", 3, 8'd14, 3'b000);
		set_trace(13, "jump no link", 5, 8'd15, 3'b000);
		set_trace(14, "spin first", 5, 8'd15, 3'b000);
		set_trace(15, "spin second", 5, 8'd15, 3'b000);

		reg_expect[0] = 16'h0000;
		reg_expect[1] = 16'h0025;
		reg_expect[2] = 16'h0002;
		reg_expect[3] = 16'h000c;
		reg_expect[4] = 16'hffa6;
		reg_expect[5] = 16'h0080;
		reg_expect[6] = 16'hffa6;
		reg_expect[7] = 16'h000f;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		cycle++;
	endtask

	// one load port write per reset cycle
	task automatic load_program();
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			load_en   = (i < PROG_LEN);
			load_addr = i[7:0];
			load_data = (i < PROG_LEN) ? prog[i] : 16'h0000;
			@(posedge clk);
			#1;
		end
		load_en = 1'b0;
	endtask

	task automatic wait_retire(output int cycles);
		int waited;
		waited = 0;
		while (retire !== 1'b1)
		begin
			if (waited == RETIRE_TIMEOUT)
			begin
				$display("timeout: no instruction retired within %0d cycles", RETIRE_TIMEOUT);
				$display("Checks failed");
				$fatal(1, "retire timeout");
			end
			else
			begin
				next_cycle();
				waited++;
			end
		end
		cycles = cycle - last_retire;
		last_retire = cycle;
	endtask

	task automatic read_reg(input int idx, output logic [15:0] value);
		dbg_idx = idx[2:0];
		@(posedge clk);
		#1;
		value = dbg_data;
	endtask

	initial
	begin
		logic [15:0] value;
		int          cycles;

		cycle       = 0;
		last_retire = 0;
		reset       = 1'b1;
		load_en     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		dbg_idx     = '0;

		build_tables();
		load_program();
		reset = 1'b0;
		// first cycle after reset is FETCH of address 0
		cycle = 1;

		for (int i = 0; i < TRACE_LEN; i++)
		begin
			wait_retire(cycles);
			check_value({trace_name[i], " cycles"}, trace_cycles[i], cycles);
			next_cycle();
			check_value({trace_name[i], " pc"}, trace_next_pc[i], pc);
			check_value({trace_name[i], " flags"}, trace_flags[i], flags);
		end

		// core is spinning on the last jump, registers hold still
		for (int r = 0; r < 8; r++)
		begin
			read_reg(r, value);
			check_value($sformatf("register r%0d", r), reg_expect[r], value);
		end

		// reset lands in the retiring state of the spinning jump
		wait_retire(cycles);
		reset = 1'b1;
		#1;
		check_value("retire under reset", 32'd0, retire);
		next_cycle();
		next_cycle();
		check_value("pc under reset", 32'd0, pc);
		read_reg(4, value);
		check_value("r4 cleared by reset", 32'd0, value);

		$display("All checks passed");
		$finish;
	end

endmodule

// File: vlog.f
hw/cpu_pkg.sv
hw/cpu_fsm.sv
hw/reg_file.sv
hw/alu.sv
hw/pc_unit.sv
hw/unified_mem.sv
hw/cpu_top.sv
tb/cpu_tb.sv
